//--- sim.f
+incdir+hw
hw/pipe_ctrl_pkg.sv
hw/trap_pkg.sv
hw/data_hazard.sv
hw/pipe_control.sv
hw/trap_csr.sv
hw/pc_gen.sv
hw/pipe_ctrl_top.sv
verification/pipe_ctrl_chk.sv
verification/pipe_ctrl_tb.sv

//--- verification/pipe_ctrl_tb.sv
`include "core_macros.svh"

module pipe_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import pipe_ctrl_pkg::*;
    import trap_pkg::*;

    localparam int PERIOD       = 100;
    localparam int N_RAND       = 200;
    localparam int TOTAL_CYCLES = 16 + 9 + N_RAND + 40;   // reset, step, random, directed

    logic                clock;
    logic                rst_n;
    logic                idu_valid, mret_flag, ecall_flag;
    logic [`REG_AW-1:0]  idu_rs1, idu_rs2, exu_rd, mem_rd;
    logic [`XLEN-1:0]    idu_pc, idu_rs1_value, idu_rs2_value;
    logic                exu_valid, exu_rf_wen, mem_ren_exu;
    logic                jump_flag, branch_flag, fence_i_flag;
    logic [`XLEN-1:0]    exu_pc, exu_imm, exu_result;
    logic                mem_valid, mem_rf_wen, mem_ren;
    logic [`XLEN-1:0]    mem_alu_result, mem_rdata;
    logic                csr_wen;
    logic [11:0]         csr_addr;
    logic [`XLEN-1:0]    csr_wdata;
    logic [`XLEN-1:0]    exu_rs1_in, exu_rs2_in, redirect_pc, pc, mepc, mcause;
    logic                redirect, icache_clr, stall;
    redirect_t           redirect_cause;

    logic [`XLEN-1:0]    m_pc, m_mtvec, m_mepc, m_mcause;   // expected state
    int                  seed = 82;
    int                  checks = 0;
    int                  errors = 0;
    int                  test_base = 0;

    pipe_ctrl_top dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(PERIOD * TOTAL_CYCLES * 3 / 2);
        $display("run timed out after %0d cycles", TOTAL_CYCLES * 3 / 2);
        $display("Result: FAILED");
        $finish;
    end

    function automatic logic [`XLEN-1:0] exp_fwd(input logic [`REG_AW-1:0] rs,
                                                 input logic [`XLEN-1:0] reg_value);
        if (exu_valid && exu_rf_wen && exu_rd != '0 && exu_rd == rs)
            return exu_result;
        if (mem_valid && mem_rf_wen && mem_rd != '0 && mem_rd == rs)
            return mem_ren ? mem_rdata : mem_alu_result;
        return reg_value;
    endfunction

    // exu causes before idu causes
    function automatic redirect_t exp_redirect(output logic [`XLEN-1:0] target);
        target = '0;
        if (exu_valid && jump_flag) begin
            target = exu_result;
            return RD_JUMP;
        end
        if (exu_valid && branch_flag && exu_result[0]) begin
            target = exu_pc + exu_imm;
            return RD_BRANCH;
        end
        if (exu_valid && fence_i_flag) begin
            target = exu_pc + `INSN_STEP;
            return RD_FENCE;
        end
        if (idu_valid && mret_flag) begin
            target = m_mepc;
            return RD_MRET;
        end
        if (idu_valid && ecall_flag) begin
            target = m_mtvec;
            return RD_ECALL;
        end
        return RD_NONE;
    endfunction

    function automatic logic [`XLEN-1:0] exp_pc_next(input logic [`XLEN-1:0] cur,
                                                     input logic redir,
                                                     input logic [`XLEN-1:0] target,
                                                     input logic hold);
        if (redir)
            return target;
        if (hold)
            return cur;
        return cur + `INSN_STEP;
    endfunction

    task automatic check_val(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] expv);
        checks++;
        assert (got === expv) else begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, expv);
        end
    endtask

    task automatic compare_cycle();
        redirect_t        cause;
        logic [`XLEN-1:0] target;
        logic             exp_stall;
        if (!rst_n) begin
            m_pc     = `RESET_PC;
            m_mtvec  = '0;
            m_mepc   = '0;
            m_mcause = '0;
        end else begin
            cause     = exp_redirect(target);
            exp_stall = idu_valid && exu_valid && mem_ren_exu && exu_rd != '0 &&
                        (exu_rd == idu_rs1 || exu_rd == idu_rs2);
            check_val("exu_rs1_in", exu_rs1_in, exp_fwd(idu_rs1, idu_rs1_value));
            check_val("exu_rs2_in", exu_rs2_in, exp_fwd(idu_rs2, idu_rs2_value));
            check_val("redirect", `XLEN'(redirect), `XLEN'(cause != RD_NONE));
            check_val("redirect_cause", `XLEN'(redirect_cause), `XLEN'(cause));
            check_val("icache_clr", `XLEN'(icache_clr), `XLEN'(cause == RD_FENCE));
            check_val("stall", `XLEN'(stall), `XLEN'(exp_stall));
            check_val("pc", pc, m_pc);
            check_val("mepc", mepc, m_mepc);
            check_val("mcause", mcause, m_mcause);
            if (cause != RD_NONE)
                check_val("redirect_pc", redirect_pc, target);
            // advance the model across the coming edge
            m_pc = exp_pc_next(m_pc, cause != RD_NONE, target, exp_stall);
            if (csr_wen && csr_addr == CSR_MTVEC)
                m_mtvec = {csr_wdata[`XLEN-1:2], 2'b00};
            if (cause == RD_ECALL) begin
                m_mepc   = idu_pc;
                m_mcause = CAUSE_ECALL_M;
            end else if (csr_wen && csr_addr == CSR_MEPC) begin
                m_mepc = {csr_wdata[`XLEN-1:2], 2'b00};
            end
        end
    endtask

    always begin
        @(negedge clock);
        #(PERIOD / 2 - 1);   // just ahead of the rising edge
        compare_cycle();
    end

    task automatic idle_inputs();
        {idu_valid, mret_flag, ecall_flag, exu_valid, exu_rf_wen, mem_ren_exu, jump_flag,
         branch_flag, fence_i_flag, mem_valid, mem_rf_wen, mem_ren, csr_wen} = '0;
        {idu_rs1, idu_rs2, exu_rd, mem_rd} = '0;
        {idu_pc, idu_rs1_value, idu_rs2_value, exu_pc, exu_imm, exu_result,
         mem_alu_result, mem_rdata, csr_wdata} = '0;
        csr_addr = '0;
    endtask

    task automatic end_test(input string name);
        @(negedge clock);
        idle_inputs();
        $display("test %s done, %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    task automatic forward_random();
        repeat (N_RAND) begin
            @(negedge clock);
            idu_valid      = 1'($random(seed));
            idu_rs1        = 5'($random(seed) & 3);   // small range gives matches and x0
            idu_rs2        = 5'($random(seed) & 3);
            exu_rd         = 5'($random(seed) & 3);
            mem_rd         = 5'($random(seed) & 3);
            exu_valid      = 1'($random(seed));
            exu_rf_wen     = 1'($random(seed));
            mem_ren_exu    = 1'($random(seed));
            mem_valid      = 1'($random(seed));
            mem_rf_wen     = 1'($random(seed));
            mem_ren        = 1'($random(seed));
            idu_rs1_value  = $random(seed);
            idu_rs2_value  = $random(seed);
            exu_result     = $random(seed);
            mem_alu_result = $random(seed);
            mem_rdata      = $random(seed);
        end
    endtask

    task automatic load_use(input logic on_rs2, input logic with_jump);
        @(negedge clock);
        idle_inputs();
        idu_valid   = 1'b1;
        idu_rs1     = on_rs2 ? 5'd3 : 5'd7;
        idu_rs2     = on_rs2 ? 5'd7 : 5'd3;
        exu_valid   = 1'b1;
        exu_rf_wen  = 1'b1;
        exu_rd      = 5'd7;
        mem_ren_exu = 1'b1;
        jump_flag   = with_jump;
        exu_result  = 32'h8000_5000;
    endtask

    task automatic exu_redirect(input logic j, input logic b, input logic f,
                                input logic [`XLEN-1:0] result);
        @(negedge clock);
        idle_inputs();
        exu_valid    = 1'b1;
        exu_pc       = 32'h8000_1000;
        exu_imm      = 32'h0000_0040;
        exu_result   = result;   // bit 0 is the branch outcome
        jump_flag    = j;
        branch_flag  = b;
        fence_i_flag = f;
        @(negedge clock);
        idle_inputs();
    endtask

    task automatic trap_sequence();
        @(negedge clock);
        idle_inputs();
        csr_wen    = 1'b1;
        csr_addr   = CSR_MTVEC;
        csr_wdata  = 32'h8000_0103;
        @(negedge clock);
        csr_addr   = 12'h340;   // unmapped here
        csr_wdata  = 32'hdead_beef;
        @(negedge clock);
        idle_inputs();
        idu_valid  = 1'b1;
        idu_pc     = 32'h8000_0a44;
        ecall_flag = 1'b1;
        csr_wen    = 1'b1;      // loses to the trap capture
        csr_addr   = CSR_MEPC;
        csr_wdata  = 32'h1234_5678;
        @(negedge clock);
        idle_inputs();
        csr_wen    = 1'b1;      // low bits dropped on write
        csr_addr   = CSR_MEPC;
        csr_wdata  = 32'h8000_0a4a;
        @(negedge clock);
        idle_inputs();
        idu_valid  = 1'b1;
        mret_flag  = 1'b1;
    endtask

    initial begin
        rst_n = 1'b0;
        idle_inputs();
        repeat (16) @(negedge clock);
        rst_n = 1'b1;
        repeat (8) @(negedge clock);
        end_test("reset_step");
        forward_random();
        end_test("forwarding");
        load_use(1'b0, 1'b0);
        load_use(1'b1, 1'b0);
        end_test("load_use");
        exu_redirect(1'b1, 1'b0, 1'b0, 32'h8000_2000);
        exu_redirect(1'b0, 1'b1, 1'b0, 32'h0000_0001);
        exu_redirect(1'b0, 1'b1, 1'b0, 32'h0000_0000);
        exu_redirect(1'b0, 1'b0, 1'b1, 32'h0000_0000);
        exu_redirect(1'b1, 1'b0, 1'b1, 32'h8000_3000);
        exu_redirect(1'b0, 1'b1, 1'b1, 32'h0000_0001);
        exu_redirect(1'b0, 1'b1, 1'b1, 32'h0000_0000);
        load_use(1'b0, 1'b1);
        end_test("exu_redirect");
        trap_sequence();
        end_test("traps");
        @(negedge clock);
        exu_valid  = 1'b1;
        jump_flag  = 1'b1;
        exu_result = 32'h8000_4000;
        idu_valid  = 1'b1;
        idu_pc     = 32'h8000_0ff0;
        ecall_flag = 1'b1;
        end_test("exu_over_idu");
        @(negedge clock);
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, dut0.chk0.fails);
        if (errors == 0 && dut0.chk0.fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- verification/pipe_ctrl_chk.sv
`include "core_macros.svh"

module pipe_ctrl_chk (
    input logic             clock,
    input logic             rst_n,
    input logic             redirect,
    input logic             stall,
    input logic             icache_clr,
    input logic [`XLEN-1:0] redirect_pc,
    input logic [`XLEN-1:0] pc,
    input logic [`XLEN-1:0] mepc,
    input logic [`XLEN-1:0] mcause
);
    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;

    clr_needs_redirect: assert property (@(posedge clock) disable iff (!rst_n)
        icache_clr |-> redirect)
        else begin
            fails++;
            $error("icache_clr raised without redirect");
        end

    // a flush must not be swallowed by a load-use hold
    redirect_beats_stall: assert property (@(posedge clock) disable iff (!rst_n)
        (redirect && stall) |=> (pc == $past(redirect_pc)))
        else begin
            fails++;
            $error("redirect during stall did not load redirect_pc");
        end

    pc_aligned: assert property (@(posedge clock) disable iff (!rst_n)
        pc[1:0] == 2'b00)
        else begin
            fails++;
            $error("pc lost word alignment");
        end

    quiet_after_reset: assert property (@(posedge clock)
        !rst_n |=> (pc == `RESET_PC && mepc == '0 && mcause == '0 &&
                    !redirect && !stall && !icache_clr))
        else begin
            fails++;
            $error("outputs not at reset values");
        end

endmodule

bind pipe_ctrl_top pipe_ctrl_chk chk0 (.*);

//--- hw/pipe_ctrl_top.sv
`include "core_macros.svh"

module pipe_ctrl_top (
    input  logic                     clock,
    input  logic                     rst_n,

    // decode stage
    input  logic                     idu_valid,
    input  logic [`XLEN-1:0]         idu_pc,
    input  logic [`REG_AW-1:0]       idu_rs1,
    input  logic [`REG_AW-1:0]       idu_rs2,
    input  logic [`XLEN-1:0]         idu_rs1_value,
    input  logic [`XLEN-1:0]         idu_rs2_value,
    input  logic                     mret_flag,
    input  logic                     ecall_flag,

    // execute stage
    input  logic                     exu_valid,
    input  logic [`XLEN-1:0]         exu_pc,
    input  logic [`XLEN-1:0]         exu_imm,
    input  logic [`XLEN-1:0]         exu_result,
    input  logic [`REG_AW-1:0]       exu_rd,
    input  logic                     exu_rf_wen,
    input  logic                     mem_ren_exu,   // exu holds a load
    input  logic                     jump_flag,
    input  logic                     branch_flag,
    input  logic                     fence_i_flag,

    // memory stage
    input  logic                     mem_valid,
    input  logic [`REG_AW-1:0]       mem_rd,
    input  logic                     mem_rf_wen,
    input  logic                     mem_ren,
    input  logic [`XLEN-1:0]         mem_alu_result,
    input  logic [`XLEN-1:0]         mem_rdata,

    input  logic                     csr_wen,
    input  logic [11:0]              csr_addr,
    input  logic [`XLEN-1:0]         csr_wdata,

    output logic [`XLEN-1:0]         exu_rs1_in,
    output logic [`XLEN-1:0]         exu_rs2_in,
    output logic                     redirect,
    output logic [`XLEN-1:0]         redirect_pc,
    output pipe_ctrl_pkg::redirect_t redirect_cause,
    output logic                     icache_clr,
    output logic                     stall,
    output logic [`XLEN-1:0]         pc,
    output logic [`XLEN-1:0]         mepc,
    output logic [`XLEN-1:0]         mcause
);
    import pipe_ctrl_pkg::*;

    fwd_sel_t         rs1_sel;
    fwd_sel_t         rs2_sel;
    logic [`XLEN-1:0] mtvec;

    data_hazard data_hazard0 (
        .idu_rs1        (idu_rs1),
        .idu_rs2        (idu_rs2),
        .exu_rd         (exu_rd),
        .mem_rd         (mem_rd),
        .idu_valid      (idu_valid),
        .exu_valid      (exu_valid),
        .mem_valid      (mem_valid),
        .exu_rf_wen     (exu_rf_wen),
        .mem_rf_wen     (mem_rf_wen),
        .mem_ren        (mem_ren),
        .mem_ren_exu    (mem_ren_exu),
        .rs1_sel        (rs1_sel),
        .rs2_sel        (rs2_sel),
        .stall          (stall)
    );

    pipe_control pipe_control0 (
        .rs1_sel        (rs1_sel),
        .rs2_sel        (rs2_sel),
        .idu_rs1_value  (idu_rs1_value),
        .idu_rs2_value  (idu_rs2_value),
        .exu_result     (exu_result),
        .mem_alu_result (mem_alu_result),
        .mem_rdata      (mem_rdata),
        .exu_pc         (exu_pc),
        .exu_imm        (exu_imm),
        .mepc           (mepc),
        .mtvec          (mtvec),
        .idu_valid      (idu_valid),
        .exu_valid      (exu_valid),
        .jump_flag      (jump_flag),
        .branch_flag    (branch_flag),
        .fence_i_flag   (fence_i_flag),
        .mret_flag      (mret_flag),
        .ecall_flag     (ecall_flag),
        .exu_rs1_in     (exu_rs1_in),
        .exu_rs2_in     (exu_rs2_in),
        .redirect_pc    (redirect_pc),
        .redirect       (redirect),
        .icache_clr     (icache_clr),
        .redirect_cause (redirect_cause)
    );

    trap_csr trap_csr0 (
        .clock          (clock),
        .rst_n          (rst_n),
        .csr_wen        (csr_wen),
        .csr_addr       (csr_addr),
        .csr_wdata      (csr_wdata),
        .idu_pc         (idu_pc),
        .redirect_cause (redirect_cause),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .mcause         (mcause)
    );

    pc_gen pc_gen0 (
        .clock          (clock),
        .rst_n          (rst_n),
        .redirect       (redirect),
        .stall          (stall),
        .redirect_pc    (redirect_pc),
        .pc             (pc)
    );

endmodule

//--- hw/pc_gen.sv
`include "core_macros.svh"

module pc_gen (
    input  logic             clock,
    input  logic             rst_n,

    input  logic             redirect,
    input  logic             stall,
    input  logic [`XLEN-1:0] redirect_pc,

    output logic [`XLEN-1:0] pc
);

    logic [`XLEN-1:0] pc_seq;

    assign pc_seq = pc + `XLEN'(`INSN_STEP);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;  // flush wins over a load-use hold
        end else if (!stall) begin
            pc <= pc_seq;
        end
    end

endmodule

//--- hw/trap_csr.sv
`include "core_macros.svh"

module trap_csr (
    input  logic                     clock,
    input  logic                     rst_n,

    input  logic                     csr_wen,
    input  logic [11:0]              csr_addr,
    input  logic [`XLEN-1:0]         csr_wdata,

    input  logic [`XLEN-1:0]         idu_pc,
    input  pipe_ctrl_pkg::redirect_t redirect_cause,

    output logic [`XLEN-1:0]         mtvec,
    output logic [`XLEN-1:0]         mepc,
    output logic [`XLEN-1:0]         mcause
);
    import pipe_ctrl_pkg::*;
    import trap_pkg::*;

    logic             trap_take;
    logic             wr_mtvec;
    logic             wr_mepc;
    logic [`XLEN-1:0] wdata_aligned;

    assign trap_take     = (redirect_cause == RD_ECALL);
    assign wr_mtvec      = csr_wen && (csr_addr == CSR_MTVEC);
    assign wr_mepc       = csr_wen && (csr_addr == CSR_MEPC);
    assign wdata_aligned = {csr_wdata[`XLEN-1:2], 2'b00};    // word aligned only

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mtvec  <= '0;
            mepc   <= '0;
            mcause <= '0;
        end else begin
            if (wr_mtvec) begin
                mtvec <= wdata_aligned;
            end

            // trap entry beats a software write to mepc
            if (trap_take) begin
                mepc   <= idu_pc;
                mcause <= CAUSE_ECALL_M;
            end else if (wr_mepc) begin
                mepc <= wdata_aligned;
            end
        end
    end

endmodule

//--- hw/pipe_control.sv
`include "core_macros.svh"

module pipe_control (
    input  pipe_ctrl_pkg::fwd_sel_t  rs1_sel,
    input  pipe_ctrl_pkg::fwd_sel_t  rs2_sel,

    input  logic [`XLEN-1:0]         idu_rs1_value,
    input  logic [`XLEN-1:0]         idu_rs2_value,
    input  logic [`XLEN-1:0]         exu_result,
    input  logic [`XLEN-1:0]         mem_alu_result,
    input  logic [`XLEN-1:0]         mem_rdata,
    input  logic [`XLEN-1:0]         exu_pc,
    input  logic [`XLEN-1:0]         exu_imm,
    input  logic [`XLEN-1:0]         mepc,
    input  logic [`XLEN-1:0]         mtvec,

    input  logic                     idu_valid,
    input  logic                     exu_valid,
    input  logic                     jump_flag,
    input  logic                     branch_flag,
    input  logic                     fence_i_flag,
    input  logic                     mret_flag,
    input  logic                     ecall_flag,

    output logic [`XLEN-1:0]         exu_rs1_in,
    output logic [`XLEN-1:0]         exu_rs2_in,
    output logic [`XLEN-1:0]         redirect_pc,
    output logic                     redirect,
    output logic                     icache_clr,
    output pipe_ctrl_pkg::redirect_t redirect_cause
);
    import pipe_ctrl_pkg::*;

    logic branch_taken;

    function automatic logic [`XLEN-1:0] fwd_mux(
        input fwd_sel_t         sel,
        input logic [`XLEN-1:0] reg_value,
        input logic [`XLEN-1:0] exu_value,
        input logic [`XLEN-1:0] mem_alu,
        input logic [`XLEN-1:0] mem_load
    );
        logic [`XLEN-1:0] value;
        case (sel)
            FWD_EXU:      value = exu_value;
            FWD_MEM_ALU:  value = mem_alu;
            FWD_MEM_LOAD: value = mem_load;
            default:      value = reg_value;
        endcase
        return value;
    endfunction

    assign exu_rs1_in = fwd_mux(rs1_sel, idu_rs1_value, exu_result, mem_alu_result, mem_rdata);
    assign exu_rs2_in = fwd_mux(rs2_sel, idu_rs2_value, exu_result, mem_alu_result, mem_rdata);

    assign branch_taken = branch_flag && exu_result[0];    // compare outcome in bit 0

    // exu is older than idu, so its causes come first
    always_comb begin
        redirect_cause = RD_NONE;
        if (exu_valid && jump_flag) begin
            redirect_cause = RD_JUMP;
        end else if (exu_valid && branch_taken) begin
            redirect_cause = RD_BRANCH;
        end else if (exu_valid && fence_i_flag) begin
            redirect_cause = RD_FENCE;
        end else if (idu_valid && mret_flag) begin
            redirect_cause = RD_MRET;
        end else if (idu_valid && ecall_flag) begin
            redirect_cause = RD_ECALL;
        end
    end

    always_comb begin
        case (redirect_cause)
            RD_JUMP:   redirect_pc = exu_result;
            RD_BRANCH: redirect_pc = exu_pc + exu_imm;
            RD_FENCE:  redirect_pc = exu_pc + `XLEN'(`INSN_STEP);  // refetch next insn
            RD_MRET:   redirect_pc = mepc;
            RD_ECALL:  redirect_pc = mtvec;
            default:   redirect_pc = '0;
        endcase
    end

    assign redirect   = (redirect_cause != RD_NONE);
    assign icache_clr = (redirect_cause == RD_FENCE);

endmodule

//--- hw/data_hazard.sv
`include "core_macros.svh"

module data_hazard (
    input  logic [`REG_AW-1:0]      idu_rs1,
    input  logic [`REG_AW-1:0]      idu_rs2,
    input  logic [`REG_AW-1:0]      exu_rd,
    input  logic [`REG_AW-1:0]      mem_rd,

    input  logic                    idu_valid,
    input  logic                    exu_valid,
    input  logic                    mem_valid,
    input  logic                    exu_rf_wen,
    input  logic                    mem_rf_wen,
    input  logic                    mem_ren,
    input  logic                    mem_ren_exu,

    output pipe_ctrl_pkg::fwd_sel_t rs1_sel,
    output pipe_ctrl_pkg::fwd_sel_t rs2_sel,
    output logic                    stall
);
    import pipe_ctrl_pkg::*;

    logic exu_fwd_ok;   // exu will write a real register
    logic mem_fwd_ok;
    logic load_use;

    assign exu_fwd_ok = exu_valid && exu_rf_wen && (exu_rd != '0);
    assign mem_fwd_ok = mem_valid && mem_rf_wen && (mem_rd != '0);

    // youngest producer wins
    function automatic fwd_sel_t pick_src(
        input logic [`REG_AW-1:0] rs,
        input logic               exu_ok,
        input logic [`REG_AW-1:0] exu_dst,
        input logic               mem_ok,
        input logic [`REG_AW-1:0] mem_dst,
        input logic               mem_is_load
    );
        fwd_sel_t sel;
        sel = FWD_REG;
        if (exu_ok && (exu_dst == rs)) begin
            sel = FWD_EXU;
        end else if (mem_ok && (mem_dst == rs)) begin
            sel = mem_is_load ? FWD_MEM_LOAD : FWD_MEM_ALU;
        end
        return sel;
    endfunction

    assign rs1_sel = pick_src(idu_rs1, exu_fwd_ok, exu_rd, mem_fwd_ok, mem_rd, mem_ren);
    assign rs2_sel = pick_src(idu_rs2, exu_fwd_ok, exu_rd, mem_fwd_ok, mem_rd, mem_ren);

    // load data not back yet, hold decode one cycle
    assign load_use = exu_valid && mem_ren_exu && (exu_rd != '0) &&
                      ((exu_rd == idu_rs1) || (exu_rd == idu_rs2));

    assign stall = idu_valid && load_use;

endmodule

//--- hw/trap_pkg.sv
`include "core_macros.svh"

package trap_pkg;

    // machine csr addresses
    localparam logic [11:0] CSR_MTVEC = 12'h305;
    localparam logic [11:0] CSR_MEPC  = 12'h341;

    // mcause for environment call from m-mode
    localparam logic [`XLEN-1:0] CAUSE_ECALL_M = `XLEN'(11);

endpackage

//--- hw/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    // operand source for the exu inputs
    typedef enum logic [1:0] {
        FWD_REG      = 2'b00,   // register file read value
        FWD_EXU      = 2'b01,   // result of the instruction in exu
        FWD_MEM_ALU  = 2'b10,   // alu result carried in mem
        FWD_MEM_LOAD = 2'b11    // load data returned in mem
    } fwd_sel_t;

    // why the fetch stream is being redirected
    typedef enum logic [2:0] {
        RD_NONE   = 3'd0,
        RD_JUMP   = 3'd1,   // jal / jalr, target from exu
        RD_BRANCH = 3'd2,   // taken branch
        RD_FENCE  = 3'd3,   // fence.i refetch
        RD_MRET   = 3'd4,   // return to mepc
        RD_ECALL  = 3'd5    // trap to mtvec
    } redirect_t;

endpackage

//--- hw/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and address width
`define XLEN 32

// register index width, x0..x31
`define REG_AW 5

// first fetch address out of reset
`define RESET_PC 32'h8000_0000

// sequential fetch increment, bytes
`define INSN_STEP 4

`endif
